// ==== ind_btb_pkg.sv ====
// shared widths, depths and entry layout for the indirect-branch target buffer
// every design file reaches these through ind_btb_pkg:: scoped names
package ind_btb_pkg;

  // index and path history
  localparam int unsigned idx_w      = 8;
  localparam int unsigned path_w     = 8;
  localparam int unsigned path_depth = 4;
  // index bits contributed by each history entry
  localparam int unsigned seg_w      = idx_w / path_depth;
  localparam int unsigned lane_cnt   = 4;

  // retire pc and stored target
  localparam int unsigned pc_w       = 39;
  localparam int unsigned tgt_w      = 20;

  // privilege field, machine mode out of reset
  localparam int unsigned priv_w     = 2;
  localparam logic [priv_w-1:0] priv_reset = 2'b11;

  // entry is {valid, priv, target}
  localparam int unsigned entry_w    = 1 + priv_w + tgt_w;

  // storage split into banks, bank number is the index msbs
  localparam int unsigned bank_cnt   = 4;
  localparam int unsigned bank_depth = 64;
  localparam int unsigned bank_aw    = $clog2(bank_depth);
  localparam int unsigned bank_sel_w = $clog2(bank_cnt);

  // invalidation sweep starts at the top index
  localparam logic [idx_w-1:0] inv_start = 8'hff;

  typedef logic [idx_w-1:0]      idx_t;
  typedef logic [path_w-1:0]     path_t;
  typedef logic [entry_w-1:0]    entry_t;
  typedef logic [bank_sel_w-1:0] bank_sel_t;

  // one full path history, entry 0 is the youngest
  typedef path_t hist_t [path_depth];

endpackage

// ==== ind_btb_path_hist.sv ====
// speculative and retire path histories of the indirect BTB
// produces the hashed read index (next speculative history ^ vghr) and
// the hashed write index (current retire history ^ ghr)
`timescale 1ns/100ps

module ind_btb_path_hist (
  input  logic                                dout_update_clk,
  input  logic                                cpurst_b,
  input  logic                                btb_en,
  input  logic                                inv_on,
  input  logic                                retire0_mispred,
  input  logic                                flush,
  input  logic                                check_vld,
  input  ind_btb_pkg::path_t                  check_path,
  input  logic [ind_btb_pkg::lane_cnt-1:0]    retire_jmp,
  input  ind_btb_pkg::path_t                  retire_chk_idx [ind_btb_pkg::lane_cnt],
  input  ind_btb_pkg::idx_t                   ghr,
  input  ind_btb_pkg::idx_t                   vghr,
  output ind_btb_pkg::idx_t                   rd_index,
  output ind_btb_pkg::idx_t                   wr_index
);

  ind_btb_pkg::hist_t spec_hist;
  ind_btb_pkg::hist_t spec_nxt;
  ind_btb_pkg::hist_t rtu_hist;
  ind_btb_pkg::hist_t rtu_nxt;
  logic               recover;
  logic               rtu_jmp_any;

  // entry k feeds index bits 2k+1..2k
  function automatic ind_btb_pkg::idx_t hash_idx(
    input ind_btb_pkg::hist_t hist,
    input ind_btb_pkg::idx_t  gh
  );
    ind_btb_pkg::idx_t idx;
    for (int k = 0; k < ind_btb_pkg::path_depth; k++)
    begin
      idx[k*ind_btb_pkg::seg_w +: ind_btb_pkg::seg_w] =
        hist[k][k*ind_btb_pkg::seg_w +: ind_btb_pkg::seg_w] ^
        gh[k*ind_btb_pkg::seg_w +: ind_btb_pkg::seg_w];
    end
    return idx;
  endfunction

  // ==========================================================================
  // retire path history
  // ==========================================================================
  assign rtu_jmp_any = |retire_jmp;

  // walk lanes oldest first, each jump pushes one entry
  // so the highest jumping lane ends up in entry 0
  always_comb
  begin
    rtu_nxt = rtu_hist;
    for (int l = 0; l < ind_btb_pkg::lane_cnt; l++)
    begin
      if (retire_jmp[l])
      begin
        for (int k = ind_btb_pkg::path_depth - 1; k > 0; k--)
          rtu_nxt[k] = rtu_nxt[k-1];
        rtu_nxt[0] = retire_chk_idx[l];
      end
    end
  end

  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int k = 0; k < ind_btb_pkg::path_depth; k++)
        rtu_hist[k] <= '0;
    end
    // sweep wipes history every cycle
    else if (inv_on)
    begin
      for (int k = 0; k < ind_btb_pkg::path_depth; k++)
        rtu_hist[k] <= '0;
    end
    else if (btb_en && rtu_jmp_any)
      rtu_hist <= rtu_nxt;
  end

  // ==========================================================================
  // speculative path history
  // ==========================================================================
  // mispredict or flush restores from retire side
  assign recover = retire0_mispred || flush;

  // recover wins over an ib check
  always_comb
  begin
    if (recover)
      spec_nxt = rtu_nxt;
    else if (check_vld)
    begin
      for (int k = ind_btb_pkg::path_depth - 1; k > 0; k--)
        spec_nxt[k] = spec_hist[k-1];
      spec_nxt[0] = check_path;
    end
    else
      spec_nxt = spec_hist;
  end

  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      for (int k = 0; k < ind_btb_pkg::path_depth; k++)
        spec_hist[k] <= '0;
    end
    else if (inv_on)
    begin
      for (int k = 0; k < ind_btb_pkg::path_depth; k++)
        spec_hist[k] <= '0;
    end
    else if (btb_en && (recover || check_vld))
      spec_hist <= spec_nxt;
  end

  // ==========================================================================
  // hashed indices
  // ==========================================================================
  // read sees the history as it will be after this edge
  assign rd_index = hash_idx(spec_nxt, vghr);
  assign wr_index = hash_idx(rtu_hist, ghr);

endmodule

// ==== ind_btb_ctrl.sv ====
// control of the indirect BTB storage
// runs the invalidation sweep, arbitrates sweep > write > read, picks the
// index and bank, and builds the write entry for the banks
`timescale 1ns/100ps

module ind_btb_ctrl (
  input  logic                               dout_update_clk,
  input  logic                               cpurst_b,
  input  logic                               btb_en,
  input  logic                               inv_req,
  input  logic                               jmp_detect,
  input  logic                               fifo_stall,
  input  logic                               retire0_jmp_mispred,
  input  logic [ind_btb_pkg::pc_w-1:0]       retire0_next_pc,
  input  logic [ind_btb_pkg::priv_w-1:0]     priv_mode,
  input  ind_btb_pkg::idx_t                  rd_index,
  input  ind_btb_pkg::idx_t                  wr_index,
  output logic                               inv_on,
  output logic                               inv_done,
  output logic [ind_btb_pkg::bank_cnt-1:0]   bank_wen,
  output logic [ind_btb_pkg::bank_cnt-1:0]   bank_rd,
  output logic [ind_btb_pkg::bank_aw-1:0]    bank_addr,
  output ind_btb_pkg::entry_t                wdata,
  output logic                               rd_go,
  output ind_btb_pkg::bank_sel_t             rd_bank
);

  ind_btb_pkg::idx_t      inv_cnt;
  ind_btb_pkg::idx_t      index;
  ind_btb_pkg::bank_sel_t bank_sel;
  logic                   wr_go;

  // ==========================================================================
  // invalidation sweep
  // ==========================================================================
  // counts 255 down to 0 while inv_on is set
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inv_cnt <= '0;
    else if (inv_on)
      inv_cnt <= inv_cnt - 1'b1;
    else if (inv_req)
      inv_cnt <= ind_btb_pkg::inv_start;
  end

  // status drops the edge after index 0 is cleared
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      inv_on <= 1'b0;
    else if (inv_on && (inv_cnt == '0))
      inv_on <= 1'b0;
    else if (inv_req)
      inv_on <= 1'b1;
  end

  assign inv_done = !inv_on;

  // ==========================================================================
  // arbitration
  // ==========================================================================
  // retired jump mispredict updates the entry
  assign wr_go = btb_en && retire0_jmp_mispred && !inv_on;

  // read on jump detect, no queueing when blocked
  assign rd_go = btb_en && jmp_detect && !wr_go && !fifo_stall && !inv_on;

  // index select, sweep first
  always_comb
  begin
    if (inv_on)
      index = inv_cnt;
    else if (wr_go)
      index = wr_index;
    else
      index = rd_index;
  end

  // msbs pick the bank
  assign bank_sel  = index[ind_btb_pkg::idx_w-1 -: ind_btb_pkg::bank_sel_w];
  assign bank_addr = index[ind_btb_pkg::bank_aw-1:0];
  assign rd_bank   = bank_sel;

  // per-bank strobes
  always_comb
  begin
    for (int b = 0; b < ind_btb_pkg::bank_cnt; b++)
    begin
      bank_wen[b] = (inv_on || wr_go) && (bank_sel == ind_btb_pkg::bank_sel_t'(b));
      bank_rd[b]  = rd_go && (bank_sel == ind_btb_pkg::bank_sel_t'(b));
    end
  end

  // ==========================================================================
  // write data
  // ==========================================================================
  // zero during sweep, else {valid, priv, target}
  assign wdata = inv_on ? '0
                        : {1'b1, priv_mode, retire0_next_pc[ind_btb_pkg::tgt_w-1:0]};

endmodule

// ==== ind_btb_bank.sv ====
// one 64-entry bank of the indirect BTB storage
// synchronous write, read data registered on rd
`timescale 1ns/100ps

module ind_btb_bank (
  input  logic                             dout_update_clk,
  input  logic                             wen,
  input  logic                             rd,
  input  logic [ind_btb_pkg::bank_aw-1:0]  addr,
  input  ind_btb_pkg::entry_t              wdata,
  output ind_btb_pkg::entry_t              rdata
);

  // storage array
  ind_btb_pkg::entry_t mem [ind_btb_pkg::bank_depth];

  // ==========================================================================
  // write port
  // ==========================================================================
  always_ff @(posedge dout_update_clk)
  begin
    if (wen)
      mem[addr] <= wdata;
  end

  // ==========================================================================
  // read port
  // ==========================================================================
  // ctrl never reads and writes the same cycle
  always_ff @(posedge dout_update_clk)
  begin
    if (rd)
      rdata <= mem[addr];
  end

endmodule

// ==== ind_btb_dout.sv ====
// data-out stage of the indirect BTB
// flops the read strobe and bank, then loads the selected bank data and
// the privilege sampled with the read one edge later
`timescale 1ns/100ps

module ind_btb_dout (
  input  logic                               dout_update_clk,
  input  logic                               cpurst_b,
  input  logic                               inv_on,
  input  logic                               rd_go,
  input  ind_btb_pkg::bank_sel_t             rd_bank,
  input  logic [ind_btb_pkg::priv_w-1:0]     priv_mode,
  input  ind_btb_pkg::entry_t                rdata [ind_btb_pkg::bank_cnt],
  output ind_btb_pkg::entry_t                dout,
  output logic [ind_btb_pkg::priv_w-1:0]     dout_priv_mode
);

  logic                               rd_flop;
  ind_btb_pkg::bank_sel_t             rd_bank_q;
  logic [ind_btb_pkg::priv_w-1:0]     priv_q;

  // ==========================================================================
  // read flop
  // ==========================================================================
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      rd_flop <= 1'b0;
    else if (inv_on)
      rd_flop <= 1'b0;
    else
      rd_flop <= rd_go;
  end

  // bank and priv captured with the read
  always_ff @(posedge dout_update_clk)
  begin
    if (rd_go)
    begin
      rd_bank_q <= rd_bank;
      priv_q    <= priv_mode;
    end
  end

  // ==========================================================================
  // output registers
  // ==========================================================================
  // hold between reads
  always_ff @(posedge dout_update_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dout           <= '0;
      dout_priv_mode <= ind_btb_pkg::priv_reset;
    end
    else if (rd_flop)
    begin
      dout           <= rdata[rd_bank_q];
      dout_priv_mode <= priv_q;
    end
  end

endmodule

// ==== ind_btb_top.sv ====
// top level of the indirect-branch target buffer
// joins path history, control, the bank array and the data-out stage
`timescale 1ns/100ps

module ind_btb_top (
  input  logic                               dout_update_clk,
  input  logic                               cpurst_b,
  input  logic                               btb_en,
  input  logic                               inv_req,
  input  logic                               check_vld,
  input  ind_btb_pkg::path_t                 check_path,
  input  logic                               jmp_detect,
  input  logic                               fifo_stall,
  input  logic                               retire0_mispred,
  input  logic                               flush,
  input  logic                               retire0_jmp_mispred,
  input  logic [ind_btb_pkg::pc_w-1:0]       retire0_next_pc,
  input  logic [ind_btb_pkg::lane_cnt-1:0]   retire_jmp,
  input  ind_btb_pkg::path_t                 retire_chk_idx [ind_btb_pkg::lane_cnt],
  input  ind_btb_pkg::idx_t                  ghr,
  input  ind_btb_pkg::idx_t                  vghr,
  input  logic [ind_btb_pkg::priv_w-1:0]     priv_mode,
  output ind_btb_pkg::entry_t                dout,
  output logic [ind_btb_pkg::priv_w-1:0]     dout_priv_mode,
  output logic                               inv_on,
  output logic                               inv_done
);

  ind_btb_pkg::idx_t                  rd_index;
  ind_btb_pkg::idx_t                  wr_index;
  logic [ind_btb_pkg::bank_cnt-1:0]   bank_wen;
  logic [ind_btb_pkg::bank_cnt-1:0]   bank_rd;
  logic [ind_btb_pkg::bank_aw-1:0]    bank_addr;
  ind_btb_pkg::entry_t                wdata;
  logic                               rd_go;
  ind_btb_pkg::bank_sel_t             rd_bank;
  ind_btb_pkg::entry_t                rdata [ind_btb_pkg::bank_cnt];

  // ==========================================================================
  // path history and index hash
  // ==========================================================================
  ind_btb_path_hist u_path_hist (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .btb_en          (btb_en),
    .inv_on          (inv_on),
    .retire0_mispred (retire0_mispred),
    .flush           (flush),
    .check_vld       (check_vld),
    .check_path      (check_path),
    .retire_jmp      (retire_jmp),
    .retire_chk_idx  (retire_chk_idx),
    .ghr             (ghr),
    .vghr            (vghr),
    .rd_index        (rd_index),
    .wr_index        (wr_index)
  );

  // sweep, arbitration and write data
  ind_btb_ctrl u_ctrl (
    .dout_update_clk     (dout_update_clk),
    .cpurst_b            (cpurst_b),
    .btb_en              (btb_en),
    .inv_req             (inv_req),
    .jmp_detect          (jmp_detect),
    .fifo_stall          (fifo_stall),
    .retire0_jmp_mispred (retire0_jmp_mispred),
    .retire0_next_pc     (retire0_next_pc),
    .priv_mode           (priv_mode),
    .rd_index            (rd_index),
    .wr_index            (wr_index),
    .inv_on              (inv_on),
    .inv_done            (inv_done),
    .bank_wen            (bank_wen),
    .bank_rd             (bank_rd),
    .bank_addr           (bank_addr),
    .wdata               (wdata),
    .rd_go               (rd_go),
    .rd_bank             (rd_bank)
  );

  // ==========================================================================
  // storage banks
  // ==========================================================================
  for (genvar b = 0; b < ind_btb_pkg::bank_cnt; b++)
  begin : g_bank
    ind_btb_bank u_bank (
      .dout_update_clk (dout_update_clk),
      .wen             (bank_wen[b]),
      .rd              (bank_rd[b]),
      .addr            (bank_addr),
      .wdata           (wdata),
      .rdata           (rdata[b])
    );
  end

  // registered data-out
  ind_btb_dout u_dout (
    .dout_update_clk (dout_update_clk),
    .cpurst_b        (cpurst_b),
    .inv_on          (inv_on),
    .rd_go           (rd_go),
    .rd_bank         (rd_bank),
    .priv_mode       (priv_mode),
    .rdata           (rdata),
    .dout            (dout),
    .dout_priv_mode  (dout_priv_mode)
  );

endmodule

// ==== tb_ind_btb.sv ====
// self-checking testbench for the indirect-branch target buffer
// a cycle model follows the DUT inputs at each rising edge
// and a comparing process checks every output on the falling edge
// directed checks build their expected values from the entry and index rules
`timescale 1ns/100ps

module tb_ind_btb;

  logic                               dout_update_clk;
  logic                               cpurst_b;
  logic                               btb_en;
  logic                               inv_req;
  logic                               check_vld;
  ind_btb_pkg::path_t                 check_path;
  logic                               jmp_detect;
  logic                               fifo_stall;
  logic                               retire0_mispred;
  logic                               flush;
  logic                               retire0_jmp_mispred;
  logic [ind_btb_pkg::pc_w-1:0]       retire0_next_pc;
  logic [ind_btb_pkg::lane_cnt-1:0]   retire_jmp;
  ind_btb_pkg::path_t                 retire_chk_idx [ind_btb_pkg::lane_cnt];
  ind_btb_pkg::idx_t                  ghr;
  ind_btb_pkg::idx_t                  vghr;
  logic [ind_btb_pkg::priv_w-1:0]     priv_mode;
  ind_btb_pkg::entry_t                dout;
  logic [ind_btb_pkg::priv_w-1:0]     dout_priv_mode;
  logic                               inv_on;
  logic                               inv_done;

  integer seed;
  int     n_checks;
  int     n_errors;

  // model histories are packed with entry 0 youngest
  logic [3:0][7:0]     m_spec;
  logic [3:0][7:0]     m_rtu;
  ind_btb_pkg::entry_t m_mem [256];
  ind_btb_pkg::entry_t m_dout;
  logic [1:0]          m_priv;
  logic                m_inv_on;
  ind_btb_pkg::idx_t   m_inv_idx;
  logic                m_rd_vld;
  logic [24:0]         m_rd_data;
  logic [3:0][7:0]     chk_lanes;

  // directed test scratch
  ind_btb_pkg::idx_t   wr_ghr;
  ind_btb_pkg::idx_t   wr_idx;
  logic [38:0]         wr_pc;
  logic [1:0]          wr_priv;
  logic [1:0]          rd_priv;
  ind_btb_pkg::entry_t dout_hold;

  ind_btb_top u_dut (.*);

  assign chk_lanes = {retire_chk_idx[3], retire_chk_idx[2], retire_chk_idx[1],
                      retire_chk_idx[0]};

  initial
  begin
    dout_update_clk = 1'b0;
    forever #20 dout_update_clk = ~dout_update_clk;
  end

  // ==========================================================================
  // reference model
  // ==========================================================================
  // index bit b comes from history entry b/2
  function automatic ind_btb_pkg::idx_t fold_hist(input logic [3:0][7:0] h,
                                                  input ind_btb_pkg::idx_t g);
    ind_btb_pkg::idx_t idx;
    for (int b = 0; b < 8; b++)
      idx[b] = h[b/2][b] ^ g[b];
    return idx;
  endfunction

  // jumping lanes push in lane order so the last one ends in entry 0
  function automatic logic [3:0][7:0] push_lanes(input logic [3:0][7:0] h,
                                                 input logic [3:0] jmp,
                                                 input logic [3:0][7:0] lanes);
    logic [3:0][7:0] r;
    r = h;
    for (int l = 0; l < 4; l++)
      if (jmp[l])
        r = {r[2:0], lanes[l]};
    return r;
  endfunction

  // expected {dout, dout_priv_mode} of a read
  function automatic logic [24:0] expect_read(input ind_btb_pkg::idx_t idx,
                                              input logic [1:0] priv);
    return {m_mem[idx], priv};
  endfunction

  always @(posedge dout_update_clk)
  begin : ref_model
    logic [3:0][7:0] rtu_n;
    logic [3:0][7:0] spec_n;
    logic            wr_go;
    logic            rd_go;
    if (!cpurst_b)
    begin
      m_spec    = '0;
      m_rtu     = '0;
      m_dout    = '0;
      m_priv    = 2'b11;
      m_inv_on  = 1'b0;
      m_inv_idx = '0;
      m_rd_vld  = 1'b0;
      m_rd_data = '0;
      for (int i = 0; i < 256; i++)
        m_mem[i] = '0;
    end
    else
    begin
      rtu_n = push_lanes(m_rtu, retire_jmp, chk_lanes);
      if (retire0_mispred || flush)
        spec_n = rtu_n;
      else if (check_vld)
        spec_n = {m_spec[2:0], check_path};
      else
        spec_n = m_spec;
      wr_go = btb_en && retire0_jmp_mispred && !m_inv_on;
      rd_go = btb_en && jmp_detect && !wr_go && !fifo_stall && !m_inv_on;
      // output regs take the read started one edge earlier
      if (m_rd_vld)
        {m_dout, m_priv} = m_rd_data;
      m_rd_vld = rd_go;
      if (rd_go)
        m_rd_data = expect_read(fold_hist(spec_n, vghr), priv_mode);
      if (wr_go)
        m_mem[fold_hist(m_rtu, ghr)] = {1'b1, priv_mode, retire0_next_pc[19:0]};
      if (m_inv_on)
      begin
        m_mem[m_inv_idx] = '0;
        m_spec = '0;
        m_rtu  = '0;
        if (m_inv_idx == 8'd0)
          m_inv_on = 1'b0;
        else
          m_inv_idx = m_inv_idx - 8'd1;
      end
      else
      begin
        if (inv_req)
        begin
          m_inv_on  = 1'b1;
          m_inv_idx = 8'hff;
        end
        if (btb_en && (|retire_jmp))
          m_rtu = rtu_n;
        if (btb_en && (retire0_mispred || flush || check_vld))
          m_spec = spec_n;
      end
    end
  end

  // ==========================================================================
  // comparing process
  // ==========================================================================
  task automatic flag_mismatch(input string sig, input logic [31:0] exp,
                               input logic [31:0] act);
    n_errors++;
    $display("** Error at %0t: %s expected %0h, actual %0h", $time, sig, exp, act);
  endtask

  always @(negedge dout_update_clk)
  begin
    if (cpurst_b)
    begin
      n_checks++;
      assert (dout === m_dout)
        else flag_mismatch("dout", 32'(m_dout), 32'(dout));
      assert (dout_priv_mode === m_priv)
        else flag_mismatch("dout_priv_mode", 32'(m_priv), 32'(dout_priv_mode));
      assert (inv_on === m_inv_on)
        else flag_mismatch("inv_on", 32'(m_inv_on), 32'(inv_on));
      assert (inv_done === !m_inv_on)
        else flag_mismatch("inv_done", 32'(!m_inv_on), 32'(inv_done));
    end
  end

  // ==========================================================================
  // stimulus tasks
  // ==========================================================================
  task automatic set_idle();
    btb_en              = 1'b1;
    inv_req             = 1'b0;
    check_vld           = 1'b0;
    check_path          = '0;
    jmp_detect          = 1'b0;
    fifo_stall          = 1'b0;
    retire0_mispred     = 1'b0;
    flush               = 1'b0;
    retire0_jmp_mispred = 1'b0;
    retire0_next_pc     = '0;
    retire_jmp          = '0;
    for (int l = 0; l < 4; l++)
      retire_chk_idx[l] = '0;
    ghr                 = '0;
    vghr                = '0;
    priv_mode           = 2'b11;
  endtask

  // full sweep with reads held high so none may land
  task automatic run_sweep();
    int on_cycles;
    on_cycles = 0;
    set_idle();
    inv_req = 1'b1;
    @(negedge dout_update_clk);
    // a read pending from before the request has landed by now
    dout_hold  = dout;
    inv_req    = 1'b0;
    jmp_detect = 1'b1;
    while (inv_on === 1'b1 && on_cycles < 400)
    begin
      on_cycles++;
      vghr = 8'($random(seed));
      @(negedge dout_update_clk);
    end
    jmp_detect = 1'b0;
    if (on_cycles >= 400)
    begin
      n_errors++;
      $display("timeout: invalidation sweep did not finish within 400 cycles");
    end
    assert (on_cycles == 256)
      else flag_mismatch("inv_on high cycles", 32'd256, 32'(on_cycles));
    assert (dout === dout_hold)
      else flag_mismatch("dout after sweep", 32'(dout_hold), 32'(dout));
  endtask

  // write at the retire index with an optional recover and read it back
  task automatic write_read(input int rec);
    set_idle();
    wr_ghr              = 8'($random(seed));
    wr_idx              = fold_hist(m_rtu, wr_ghr);
    wr_pc               = 39'({$random(seed), $random(seed)});
    wr_priv             = 2'($random(seed));
    rd_priv             = 2'($random(seed));
    flush               = (rec == 1);
    retire0_mispred     = (rec == 2);
    retire0_jmp_mispred = 1'b1;
    ghr                 = wr_ghr;
    retire0_next_pc     = wr_pc;
    priv_mode           = wr_priv;
    @(negedge dout_update_clk);
    set_idle();
    jmp_detect = 1'b1;
    vghr       = wr_ghr;
    priv_mode  = rd_priv;
    @(negedge dout_update_clk);
    set_idle();
    @(negedge dout_update_clk);
    assert (dout === {1'b1, wr_priv, wr_pc[19:0]})
      else flag_mismatch("dout", 32'({1'b1, wr_priv, wr_pc[19:0]}), 32'(dout));
    assert (dout_priv_mode === rd_priv)
      else flag_mismatch("dout_priv_mode", 32'(rd_priv), 32'(dout_priv_mode));
  endtask

  task automatic random_cycle();
    btb_en              = ($random(seed) & 7) != 0;
    inv_req             = 1'b0;
    check_vld           = 1'($random(seed));
    check_path          = 8'($random(seed));
    jmp_detect          = 1'($random(seed));
    fifo_stall          = ($random(seed) & 3) == 0;
    retire0_mispred     = ($random(seed) & 7) == 0;
    flush               = ($random(seed) & 15) == 0;
    retire0_jmp_mispred = ($random(seed) & 3) == 0;
    retire0_next_pc     = 39'({$random(seed), $random(seed)});
    retire_jmp          = 4'($random(seed));
    for (int l = 0; l < 4; l++)
      retire_chk_idx[l] = 8'($random(seed));
    ghr                 = 8'($random(seed));
    vghr                = 1'($random(seed)) ? ghr : 8'($random(seed));
    priv_mode           = 2'($random(seed));
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial
  begin
    seed     = 36921;
    n_checks = 0;
    n_errors = 0;
    cpurst_b = 1'b0;
    set_idle();
    repeat (16) @(posedge dout_update_clk);
    @(negedge dout_update_clk);
    cpurst_b = 1'b1;
    assert (dout === '0) else flag_mismatch("dout", 32'd0, 32'(dout));
    assert (dout_priv_mode === 2'b11)
      else flag_mismatch("dout_priv_mode", 32'd3, 32'(dout_priv_mode));
    assert (inv_on === 1'b0) else flag_mismatch("inv_on", 32'd0, 32'(inv_on));
    assert (inv_done === 1'b1) else flag_mismatch("inv_done", 32'd1, 32'(inv_done));

    // clears the storage before any read
    run_sweep();
    write_read(0);

    // with btb disabled nothing moves and no write lands
    set_idle();
    btb_en              = 1'b0;
    retire0_jmp_mispred = 1'b1;
    ghr                 = wr_ghr;
    retire0_next_pc     = ~wr_pc;
    retire_jmp          = 4'hf;
    retire_chk_idx[3]   = 8'($random(seed));
    check_vld           = 1'b1;
    check_path          = 8'($random(seed));
    repeat (3) @(negedge dout_update_clk);

    // read in the same cycle as an ib check where entry 0 feeds index bits 1..0
    set_idle();
    check_vld  = 1'b1;
    check_path = 8'($random(seed)) | 8'h01;
    jmp_detect = 1'b1;
    vghr       = wr_ghr ^ {6'b0, check_path[1:0]};
    @(negedge dout_update_clk);
    set_idle();
    @(negedge dout_update_clk);
    assert (dout === {1'b1, wr_priv, wr_pc[19:0]})
      else flag_mismatch("dout", 32'({1'b1, wr_priv, wr_pc[19:0]}), 32'(dout));

    // stalled read followed by a read beside a write
    dout_hold  = dout;
    jmp_detect = 1'b1;
    fifo_stall = 1'b1;
    vghr       = ~wr_ghr;
    @(negedge dout_update_clk);
    fifo_stall          = 1'b0;
    retire0_jmp_mispred = 1'b1;
    ghr                 = 8'($random(seed));
    @(negedge dout_update_clk);
    set_idle();
    @(negedge dout_update_clk);
    assert (dout === dout_hold)
      else flag_mismatch("dout", 32'(dout_hold), 32'(dout));

    // every retire lane pattern followed by recover and read back
    for (int p = 0; p < 16; p++)
    begin
      set_idle();
      retire_jmp = 4'(p);
      for (int l = 0; l < 4; l++)
        retire_chk_idx[l] = 8'($random(seed));
      @(negedge dout_update_clk);
      write_read(1 + p % 2);
    end

    repeat (400)
    begin
      random_cycle();
      @(negedge dout_update_clk);
    end

    // second sweep wipes the last directed entry
    run_sweep();
    set_idle();
    jmp_detect = 1'b1;
    vghr       = wr_idx;
    @(negedge dout_update_clk);
    set_idle();
    @(negedge dout_update_clk);
    assert (dout === '0) else flag_mismatch("dout", 32'd0, 32'(dout));

    repeat (4) @(negedge dout_update_clk);
    $display("checked %0d cycles, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== compile.f ====
ind_btb_pkg.sv
ind_btb_path_hist.sv
ind_btb_ctrl.sv
ind_btb_bank.sv
ind_btb_dout.sv
ind_btb_top.sv
tb_ind_btb.sv

// ==== Makefile ====
# Verilator build and run of the indirect BTB testbench

TOP := tb_ind_btb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f compile.f

# pass only when the pass message shows up in the output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir
